//--- logic/dnc_num_pkg.sv
`default_nettype none

package dnc_num_pkg;

  //////////////////////////////
  // Fixed-point format
  //////////////////////////////

  // Signed Q2.14 values
  localparam int WEIGHT_W = 16;
  localparam int FRAC_W   = 14;

  // Full-precision product of two weights
  localparam int PROD_W = 32;

  // Two guard bits for the sum of three products
  localparam int SUM_W = 34;

  // Basic signed types
  typedef logic signed [WEIGHT_W-1:0] weight_t;
  typedef logic signed [PROD_W-1:0]   prod_t;
  typedef logic signed [SUM_W-1:0]    sum_t;

  // Clamp limits of a weight
  localparam weight_t WEIGHT_MAX = 16'sh7fff;
  localparam weight_t WEIGHT_MIN = 16'sh8000;

  //////////////////////////////
  // Read mode
  //////////////////////////////

  // Mode triple pi(i) of one read head
  // backward, content and forward shares
  typedef struct packed {
    weight_t backward;
    weight_t content;
    weight_t forward;
  } mode_triple_t;

endpackage

`default_nettype wire

//--- logic/dnc_stream_pkg.sv
`default_nettype none

package dnc_stream_pkg;

  //////////////////////////////
  // Sizes and indices
  //////////////////////////////

  // R read heads, N memory locations
  localparam int NUM_HEADS = 2;
  localparam int NUM_LOCS  = 4;

  localparam int HEAD_W = $clog2(NUM_HEADS);
  localparam int LOC_W  = $clog2(NUM_LOCS);

  typedef logic [HEAD_W-1:0] head_t;
  typedef logic [LOC_W-1:0]  loc_t;

  // Final index values of a frame
  localparam head_t LAST_HEAD = head_t'(NUM_HEADS - 1);
  localparam loc_t  LAST_LOC  = loc_t'(NUM_LOCS - 1);

  //////////////////////////////
  // Input stream
  //////////////////////////////

  // Per-location backward, content and forward weightings
  typedef struct packed {
    dnc_num_pkg::weight_t b;
    dnc_num_pkg::weight_t c;
    dnc_num_pkg::weight_t f;
  } elem_triple_t;

  // One 48-bit word, read as mode or as element
  typedef union packed {
    dnc_num_pkg::mode_triple_t mode;
    elem_triple_t              elem;
  } in_word_u;

  typedef struct packed {
    logic     is_mode;
    in_word_u word;
  } in_beat_t;

  //////////////////////////////
  // Internal and output beats
  //////////////////////////////

  // Sequencer to pipe, one element with its modes
  typedef struct packed {
    head_t                     head;
    loc_t                      loc;
    logic                      last;
    dnc_num_pkg::mode_triple_t modes;
    elem_triple_t              elems;
  } mix_req_t;

  // One read weight w(i,j)
  typedef struct packed {
    head_t                head;
    loc_t                 loc;
    logic                 last;
    dnc_num_pkg::weight_t w;
  } out_beat_t;

endpackage

`default_nettype wire

//--- logic/weight_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module weight_sequencer (
  input  wire                      CLK,
  input  wire                      RST,

  // Input stream
  input  wire                      in_valid,
  output logic                     in_ready,
  input  wire dnc_stream_pkg::in_beat_t in_data,

  // Request to mixing pipe
  output logic                     req_valid,
  input  wire                      req_ready,
  output dnc_stream_pkg::mix_req_t req,

  // Sticky word-order error
  output logic                     order_error
);

  import dnc_num_pkg::*;
  import dnc_stream_pkg::*;

  //////////////////////////////
  // State
  //////////////////////////////

  // High while the next word should be a mode word
  logic         expect_mode_q;

  // Current head and location
  head_t        head_q;
  loc_t         loc_q;

  // Latched pi(i) of the current head
  mode_triple_t modes_q;

  // Handshake decode
  logic accept;
  logic mode_ok;
  logic elem_ok;
  logic wrong_kind;
  logic loc_end;
  logic head_end;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // Mode words never wait on the pipe
  assign in_ready = expect_mode_q | req_ready;
  assign accept   = in_valid & in_ready;

  assign mode_ok    = accept & expect_mode_q & in_data.is_mode;
  assign elem_ok    = accept & ~expect_mode_q & ~in_data.is_mode;
  // Mode word while elements expected, or the reverse
  assign wrong_kind = accept & (expect_mode_q ^ in_data.is_mode);

  assign loc_end  = (loc_q == LAST_LOC);
  assign head_end = (head_q == LAST_HEAD);

  // Only a correctly placed element word becomes a request
  assign req_valid = in_valid & ~expect_mode_q & ~in_data.is_mode;

  always_comb begin
    req.head  = head_q;
    req.loc   = loc_q;
    // Final element of the frame
    req.last  = head_end & loc_end;
    req.modes = modes_q;
    req.elems = in_data.word.elem;
  end

  //////////////////////////////
  // Position counters
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      expect_mode_q <= 1'b1;
      head_q        <= '0;
      loc_q         <= '0;
    end else if (mode_ok) begin
      expect_mode_q <= 1'b0;
    end else if (elem_ok) begin
      if (loc_end) begin
        // Head done, wait for next mode word
        loc_q         <= '0;
        expect_mode_q <= 1'b1;
        if (head_end) begin
          head_q <= '0;
        end else begin
          head_q <= head_q + 1'b1;
        end
      end else begin
        loc_q <= loc_q + 1'b1;
      end
    end
  end

  // Mode triple latch
  always_ff @(posedge CLK) begin
    if (mode_ok) begin
      modes_q <= in_data.word.mode;
    end
  end

  //////////////////////////////
  // Order error
  //////////////////////////////

  // Set once, cleared only by reset
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      order_error <= 1'b0;
    end else if (wrong_kind) begin
      order_error <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/mode_mix_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module mode_mix_pipe (
  input  wire                       CLK,
  input  wire                       RST,

  // Request from sequencer
  input  wire                       req_valid,
  output logic                      req_ready,
  input  wire dnc_stream_pkg::mix_req_t req,

  // Output stream
  output logic                      out_valid,
  input  wire                       out_ready,
  output dnc_stream_pkg::out_beat_t out_data
);

  import dnc_num_pkg::*;
  import dnc_stream_pkg::*;

  // Stage 1 contents, tags plus three products
  typedef struct packed {
    head_t head;
    loc_t  loc;
    logic  last;
    prod_t prod_b;
    prod_t prod_c;
    prod_t prod_f;
  } stage1_t;

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Stage valids
  logic      s1_valid;
  logic      s2_valid;

  // Stage payloads
  stage1_t   s1_d;
  stage1_t   s1_q;
  out_beat_t s2_d;
  out_beat_t s2_q;

  // Stage may take new data
  logic      s1_ready;
  logic      s2_ready;

  // Stage 2 arithmetic
  sum_t      sum;
  sum_t      scaled;
  weight_t   w_sat;

  //////////////////////////////
  // Flow control
  //////////////////////////////

  // Empty, or draining this cycle
  assign s2_ready  = ~s2_valid | out_ready;
  assign s1_ready  = ~s1_valid | s2_ready;
  assign req_ready = s1_ready;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid <= req_valid;
      end
      if (s2_ready) begin
        s2_valid <= s1_valid;
      end
    end
  end

  //////////////////////////////
  // Stage 1 multiply
  //////////////////////////////

  // Sign-extend before multiplying, full 32-bit products
  always_comb begin
    s1_d.head   = req.head;
    s1_d.loc    = req.loc;
    s1_d.last   = req.last;
    s1_d.prod_b = prod_t'(req.modes.backward) * prod_t'(req.elems.b);
    s1_d.prod_c = prod_t'(req.modes.content) * prod_t'(req.elems.c);
    s1_d.prod_f = prod_t'(req.modes.forward) * prod_t'(req.elems.f);
  end

  //////////////////////////////
  // Stage 2 sum and clamp
  //////////////////////////////

  always_comb begin
    sum    = sum_t'(s1_q.prod_b) + sum_t'(s1_q.prod_c) + sum_t'(s1_q.prod_f);
    // Arithmetic shift, floor rounding
    scaled = sum >>> FRAC_W;
    if (scaled > sum_t'(WEIGHT_MAX)) begin
      w_sat = WEIGHT_MAX;
    end else if (scaled < sum_t'(WEIGHT_MIN)) begin
      w_sat = WEIGHT_MIN;
    end else begin
      w_sat = weight_t'(scaled);
    end
    s2_d.head = s1_q.head;
    s2_d.loc  = s1_q.loc;
    s2_d.last = s1_q.last;
    s2_d.w    = w_sat;
  end

  // Payload registers, loaded only on a stage advance
  always_ff @(posedge CLK) begin
    if (req_valid && s1_ready) begin
      s1_q <= s1_d;
    end
    if (s1_valid && s2_ready) begin
      s2_q <= s2_d;
    end
  end

  assign out_valid = s2_valid;
  assign out_data  = s2_q;

endmodule

`default_nettype wire

//--- logic/dnc_read_weighting.sv
`timescale 1ns/1ps
`default_nettype none

module dnc_read_weighting (
  input  wire                       CLK,
  input  wire                       RST,

  // Mode and element words
  input  wire                       in_valid,
  output logic                      in_ready,
  input  wire dnc_stream_pkg::in_beat_t in_data,

  // Read weights
  output logic                      out_valid,
  input  wire                       out_ready,
  output dnc_stream_pkg::out_beat_t out_data,

  output logic                      order_error
);

  import dnc_stream_pkg::*;

  // Sequencer to pipe
  logic     req_valid;
  logic     req_ready;
  mix_req_t req;

  //////////////////////////////
  // Position tracking
  //////////////////////////////

  weight_sequencer u_seq (
    .CLK         (CLK),
    .RST         (RST),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_data     (in_data),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req         (req),
    .order_error (order_error)
  );

  //////////////////////////////
  // Mixing pipeline
  //////////////////////////////

  mode_mix_pipe u_pipe (
    .CLK       (CLK),
    .RST       (RST),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

endmodule

`default_nettype wire

//--- bench/dnc_read_weighting_chk.sv
`timescale 1ns/1ps
`default_nettype none

module dnc_read_weighting_chk (
  input wire                            CLK,
  input wire                            RST,
  input wire                            out_valid,
  input wire                            out_ready,
  input wire dnc_stream_pkg::out_beat_t out_data,
  input wire                            order_error
);

  //////////////////////////////
  // Output stream
  //////////////////////////////

  // Stalled beat keeps valid and payload
  a_out_hold: assert property (
    @(posedge CLK) disable iff (RST)
      out_valid && !out_ready |=> out_valid && $stable(out_data)
  ) else $error("out_data changed while the beat was stalled");

  // First cycle out of reset is idle
  a_reset_idle: assert property (
    @(posedge CLK) $fell(RST) |-> !out_valid && !order_error
  ) else $error("out_valid or order_error high right after reset");

  //////////////////////////////
  // Error flag
  //////////////////////////////

  // Sticky until reset
  a_error_sticky: assert property (
    @(posedge CLK) disable iff (RST) !$fell(order_error)
  ) else $error("order_error fell without reset");

endmodule

bind dnc_read_weighting dnc_read_weighting_chk u_chk (
  .CLK         (CLK),
  .RST         (RST),
  .out_valid   (out_valid),
  .out_ready   (out_ready),
  .out_data    (out_data),
  .order_error (order_error)
);

`default_nettype wire

//--- bench/dnc_read_weighting_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dnc_read_weighting_tb;

  import dnc_num_pkg::*;
  import dnc_stream_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int NUM_ROWS    = 21;
  localparam int RAND_FRAMES = 3;
  localparam int RAND_BEATS  = RAND_FRAMES * NUM_HEADS * (NUM_LOCS + 1);

  // Input beat fields and out_ready for the first cycle of the row
  typedef struct packed {
    logic    is_mode;
    weight_t b;
    weight_t c;
    weight_t f;
    logic    rdy;
  } row_t;

  logic         CLK;
  logic         RST;
  logic         in_valid;
  logic         in_ready;
  in_beat_t     in_data;
  logic         out_valid;
  logic         out_ready;
  out_beat_t    out_data;
  logic         order_error;

  row_t         rows [NUM_ROWS];

  // Reference model
  out_beat_t    exp_q [$];
  int           acc_q [$];
  logic         m_expect_mode;
  int           m_head;
  int           m_loc;
  mode_triple_t m_modes;
  logic         exp_err;

  int           cycle;
  int           ready_run;
  int           errors;
  int           checks;
  integer       seed;

  dnc_read_weighting UUT (
    .CLK         (CLK),
    .RST         (RST),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_data     (in_data),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_data    (out_data),
    .order_error (order_error)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Watchdog with a generous budget per beat
  initial begin
    #(CLK_PERIOD * 20 * (NUM_ROWS + RAND_BEATS));
    $display("Timeout: the run did not finish within the cycle budget");
    $display("Something failed");
    $finish;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // w = pi1*b + pi2*c + pi3*f in Q2.14
  function automatic weight_t mix_weight(input mode_triple_t pi, input weight_t b,
                                         input weight_t c, input weight_t f);
    longint acc;
    acc = longint'(pi.backward) * longint'(b) + longint'(pi.content) * longint'(c)
        + longint'(pi.forward) * longint'(f);
    // Floor division by 2^14
    acc = acc >>> 14;
    if (acc > 32767) begin
      acc = 32767;
    end else if (acc < -32768) begin
      acc = -32768;
    end
    return weight_t'(acc);
  endfunction

  // Same bit positions for mode and element views
  function automatic in_beat_t make_beat(input logic is_mode, input weight_t b,
                                         input weight_t c, input weight_t f);
    in_beat_t beat;
    beat.is_mode     = is_mode;
    beat.word.elem.b = b;
    beat.word.elem.c = c;
    beat.word.elem.f = f;
    return beat;
  endfunction

  task automatic model_accept(input in_beat_t beat);
    out_beat_t e;
    if (beat.is_mode != m_expect_mode) begin
      // Wrong kind is dropped
      exp_err = 1'b1;
    end else if (beat.is_mode) begin
      m_modes       = beat.word.mode;
      m_expect_mode = 1'b0;
    end else begin
      e.head = head_t'(m_head);
      e.loc  = loc_t'(m_loc);
      e.last = (m_head == NUM_HEADS - 1) && (m_loc == NUM_LOCS - 1);
      e.w    = mix_weight(m_modes, beat.word.elem.b, beat.word.elem.c, beat.word.elem.f);
      exp_q.push_back(e);
      acc_q.push_back(cycle);
      if (m_loc == NUM_LOCS - 1) begin
        m_loc         = 0;
        m_head        = (m_head + 1) % NUM_HEADS;
        m_expect_mode = 1'b1;
      end else begin
        m_loc = m_loc + 1;
      end
    end
  endtask

  //////////////////////////////
  // Drive and check
  //////////////////////////////

  task automatic check_output();
    out_beat_t e;
    int        acc;
    checks++;
    if (exp_q.size() == 0) begin
      errors++;
      $display("ERROR at %0t: output beat with nothing expected", $time);
    end else begin
      e   = exp_q.pop_front();
      acc = acc_q.pop_front();
      if (out_data !== e) begin
        errors++;
        $display("ERROR at %0t: got h%0d l%0d last %b w %h, expected h%0d l%0d last %b w %h",
                 $time, out_data.head, out_data.loc, out_data.last, out_data.w,
                 e.head, e.loc, e.last, e.w);
      end
      // No stall since acceptance, so exactly two cycles
      if (ready_run >= cycle - acc && cycle - acc != 2) begin
        errors++;
        $display("ERROR at %0t: latency %0d cycles, expected 2", $time, cycle - acc);
      end
    end
  endtask

  // One clock with inputs set at the falling edge
  task automatic run_cycle(input logic valid, input in_beat_t beat, input logic rdy,
                           output logic took);
    @(negedge CLK);
    in_valid  = valid;
    in_data   = beat;
    out_ready = rdy;
    cycle++;
    ready_run = rdy ? ready_run + 1 : 0;
    // Settle before the rising edge
    #2;
    if (order_error !== exp_err) begin
      errors++;
      $display("ERROR at %0t: order_error %b, expected %b", $time, order_error, exp_err);
    end
    took = valid && in_ready;
    if (took) begin
      model_accept(beat);
    end
    if (out_valid && out_ready) begin
      check_output();
    end
  endtask

  task automatic send_row(input row_t row);
    logic took;
    logic rdy;
    took = 1'b0;
    rdy  = row.rdy;
    while (!took) begin
      run_cycle(1'b1, make_beat(row.is_mode, row.b, row.c, row.f), rdy, took);
      rdy = 1'b1;
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    in_beat_t rand_beat;
    logic     took;
    RST           = 1'b1;
    in_valid      = 1'b0;
    in_data       = '0;
    out_ready     = 1'b0;
    seed          = 32'h364f_401f;
    errors        = 0;
    checks        = 0;
    cycle         = 0;
    ready_run     = 0;
    m_expect_mode = 1'b1;
    m_head        = 0;
    m_loc         = 0;
    m_modes       = '0;
    exp_err       = 1'b0;

    rows = '{
      // Frame 1 with out_ready always high
      '{1'b1, 16'h4000, 16'h0000, 16'h0000, 1'b1},
      '{1'b0, 16'h1234, 16'h7fff, 16'h8000, 1'b1},
      '{1'b0, 16'hc000, 16'h0000, 16'h0000, 1'b1},
      '{1'b0, 16'h0001, 16'h0000, 16'h0000, 1'b1},
      '{1'b0, 16'hffff, 16'h0000, 16'h0000, 1'b1},
      '{1'b1, 16'h2000, 16'h1000, 16'h1000, 1'b1},
      '{1'b0, 16'h4000, 16'h4000, 16'h4000, 1'b1},
      '{1'b0, 16'h0001, 16'h0001, 16'h0003, 1'b1},
      '{1'b0, 16'hffff, 16'h0000, 16'h0000, 1'b1},
      '{1'b0, 16'hc000, 16'h2000, 16'h8000, 1'b1},
      // Frame 2 with negative modes then saturation
      '{1'b1, 16'he000, 16'hc000, 16'h3000, 1'b1},
      '{1'b0, 16'h4000, 16'h2000, 16'h1000, 1'b0},
      '{1'b0, 16'h8000, 16'h7fff, 16'h0123, 1'b1},
      '{1'b0, 16'hffff, 16'hffff, 16'hffff, 1'b0},
      '{1'b0, 16'h1111, 16'heeee, 16'h2222, 1'b1},
      '{1'b1, 16'h7fff, 16'h7fff, 16'h7fff, 1'b1},
      '{1'b0, 16'h7fff, 16'h7fff, 16'h7fff, 1'b1},
      '{1'b0, 16'h8000, 16'h8000, 16'h8000, 1'b0},
      '{1'b0, 16'h7fff, 16'h0000, 16'h0000, 1'b1},
      '{1'b0, 16'h8000, 16'h8000, 16'h0000, 1'b1},
      // Element where a mode belongs
      '{1'b0, 16'h0100, 16'h0200, 16'h0300, 1'b1}
    };

    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    #2;
    if (in_ready !== 1'b1 || out_valid !== 1'b0) begin
      errors++;
      $display("ERROR at %0t: in_ready %b out_valid %b after reset", $time, in_ready, out_valid);
    end

    for (int i = 0; i < NUM_ROWS; i++) begin
      send_row(rows[i]);
    end

    // Random frames with out_ready gaps
    for (int fr = 0; fr < RAND_FRAMES; fr++) begin
      for (int h = 0; h < NUM_HEADS; h++) begin
        for (int j = 0; j <= NUM_LOCS; j++) begin
          rand_beat = make_beat(j == 0, weight_t'($random(seed)), weight_t'($random(seed)),
                                weight_t'($random(seed)));
          took = 1'b0;
          while (!took) begin
            run_cycle(1'b1, rand_beat, ($random(seed) % 4) != 0, took);
          end
        end
      end
    end

    // Drain what is still in flight
    while (exp_q.size() != 0) begin
      run_cycle(1'b0, '0, 1'b1, took);
    end
    repeat (3) run_cycle(1'b0, '0, 1'b1, took);

    $display("Run complete: %0d errors, %0d output beats compared", errors, checks);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dnc_read.f
logic/dnc_num_pkg.sv
logic/dnc_stream_pkg.sv
logic/weight_sequencer.sv
logic/mode_mix_pipe.sv
logic/dnc_read_weighting.sv
bench/dnc_read_weighting_chk.sv
bench/dnc_read_weighting_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = dnc_read_weighting_tb
FILELIST = dnc_read.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

# Static checks over the whole file list
lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run, then look for the pass line in the log
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
